/* logic/core_pkg.sv */
`default_nettype none

package core_pkg;

  localparam int XLEN    = 32;
  localparam int IADDR_W = XLEN - 2;
  localparam int REG_W   = 5;

  typedef logic [XLEN-1:0]    xlen_t;
  typedef logic [IADDR_W-1:0] iaddr_t;
  typedef logic [REG_W-1:0]   reg_idx_t;
  typedef logic [3:0]         byte_en_t;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_PASS_B
  } alu_op_e;

  // same encoding as funct3[1:0] of the stores
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'b00,
    SIZE_HALF = 2'b01,
    SIZE_WORD = 2'b10
  } mem_size_e;

  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;

  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;
  localparam logic [2:0] F3_LW      = 3'b010;
  localparam logic [6:0] F7_SUB     = 7'b0100000;

  // addi x0, x0, 0
  localparam logic [31:0] NOP_INSTR = {12'h000, 5'd0, F3_ADD_SUB, 5'd0, OPC_OP_IMM};

  typedef struct packed {
    logic      valid;
    alu_op_e   alu_op;
    logic      use_imm;
    xlen_t     imm;
    reg_idx_t  rs1;
    reg_idx_t  rs2;
    reg_idx_t  rd;
    xlen_t     rs1_val;
    xlen_t     rs2_val;
    logic      wr_reg;
    logic      load;
    logic      store;
    mem_size_e size;
  } id_ex_t;

  typedef struct packed {
    logic      valid;
    logic      wr_reg;
    reg_idx_t  rd;
    xlen_t     result;
    logic      load;
    logic      store;
    mem_size_e size;
    xlen_t     store_data;
  } ex_mem_t;

  typedef struct packed {
    logic     en;
    reg_idx_t idx;
    xlen_t    data;
  } wb_write_t;

endpackage

`default_nettype wire

/* logic/fetch.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch (
  input  logic             clk,
  input  logic             rst_n,
  input  core_pkg::xlen_t  boot_addr,
  input  logic             load_stall,
  output logic             isram_cs,
  output core_pkg::iaddr_t isram_adr,
  output logic             fetch_valid
);
  import core_pkg::*;

  iaddr_t pc;
  logic   run;

  // no strobe while decode waits on a load
  assign isram_cs  = run & ~load_stall;
  assign isram_adr = pc;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      run <= 1'b0;
      pc  <= boot_addr[XLEN-1:2];
    end else begin
      run <= 1'b1;
      if (isram_cs) begin
        pc <= pc + iaddr_t'(1);
      end
    end
  end

  // sram keeps its output on a stall, so the slot stays live
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      fetch_valid <= 1'b0;
    end else if (!load_stall) begin
      fetch_valid <= isram_cs;
    end
  end

endmodule

`default_nettype wire

/* logic/inst_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module inst_decode (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               fetch_valid,
  input  core_pkg::xlen_t    instr_fromsram,
  input  core_pkg::xlen_t    rs1_val,
  input  core_pkg::xlen_t    rs2_val,
  output core_pkg::reg_idx_t rs1_addr,
  output core_pkg::reg_idx_t rs2_addr,
  output logic               load_stall,
  output core_pkg::id_ex_t   id_ex
);
  import core_pkg::*;

  xlen_t      instr;
  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  xlen_t      imm_i;
  xlen_t      imm_s;
  xlen_t      imm_u;
  logic       legal;
  logic       use_rs1;
  logic       use_rs2;
  logic       hit_rs1;
  logic       hit_rs2;
  id_ex_t     dec;

  // dead fetch slot decodes as a nop
  assign instr  = fetch_valid ? instr_fromsram : NOP_INSTR;
  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];
  assign imm_i  = {{20{instr[31]}}, instr[31:20]};
  assign imm_s  = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_u  = {instr[31:12], 12'h000};

  assign rs1_addr = instr[19:15];
  assign rs2_addr = instr[24:20];

  always_comb begin
    dec         = '0;
    dec.rs1     = rs1_addr;
    dec.rs2     = rs2_addr;
    dec.rd      = instr[11:7];
    dec.rs1_val = rs1_val;
    dec.rs2_val = rs2_val;
    dec.alu_op  = ALU_ADD;
    dec.size    = SIZE_WORD;
    legal       = 1'b0;
    use_rs1     = 1'b0;
    use_rs2     = 1'b0;
    case (opcode)
      OPC_OP: begin
        use_rs1    = 1'b1;
        use_rs2    = 1'b1;
        dec.wr_reg = 1'b1;
        legal      = (funct7 == 7'b0);
        case (funct3)
          F3_ADD_SUB: begin
            if (funct7 == F7_SUB) begin
              dec.alu_op = ALU_SUB;
              legal      = 1'b1;
            end
          end
          F3_XOR:  dec.alu_op = ALU_XOR;
          F3_OR:   dec.alu_op = ALU_OR;
          F3_AND:  dec.alu_op = ALU_AND;
          default: legal = 1'b0;
        endcase
      end
      OPC_OP_IMM: begin
        use_rs1     = 1'b1;
        dec.use_imm = 1'b1;
        dec.imm     = imm_i;
        dec.wr_reg  = 1'b1;
        legal       = (funct3 == F3_ADD_SUB);
      end
      OPC_LUI: begin
        dec.alu_op  = ALU_PASS_B;
        dec.use_imm = 1'b1;
        dec.imm     = imm_u;
        dec.wr_reg  = 1'b1;
        legal       = 1'b1;
      end
      OPC_LOAD: begin
        use_rs1     = 1'b1;
        dec.use_imm = 1'b1;
        dec.imm     = imm_i;
        dec.wr_reg  = 1'b1;
        dec.load    = 1'b1;
        legal       = (funct3 == F3_LW);
      end
      OPC_STORE: begin
        use_rs1     = 1'b1;
        use_rs2     = 1'b1;
        dec.use_imm = 1'b1;
        dec.imm     = imm_s;
        dec.store   = 1'b1;
        dec.size    = mem_size_e'(funct3[1:0]);
        legal       = ~funct3[2] & (funct3[1:0] != 2'b11);
      end
      default: legal = 1'b0;
    endcase
    // unknown encodings go down the pipe as a bubble
    dec.valid = legal & fetch_valid;
    if (!dec.valid) begin
      dec.wr_reg = 1'b0;
      dec.load   = 1'b0;
      dec.store  = 1'b0;
    end
  end

  assign hit_rs1 = use_rs1 & (rs1_addr == id_ex.rd);
  assign hit_rs2 = use_rs2 & (rs2_addr == id_ex.rd);

  // load data only reaches the wb bypass one cycle too late
  assign load_stall = dec.valid & id_ex.valid & id_ex.load & (id_ex.rd != '0) &
                      (hit_rs1 | hit_rs2);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      id_ex.valid  <= 1'b0;
      id_ex.wr_reg <= 1'b0;
      id_ex.load   <= 1'b0;
      id_ex.store  <= 1'b0;
    end else begin
      id_ex <= dec;
      if (load_stall) begin
        id_ex.valid  <= 1'b0;
        id_ex.wr_reg <= 1'b0;
        id_ex.load   <= 1'b0;
        id_ex.store  <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

/* logic/regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module regfile (
  input  logic                clk,
  input  logic                rst_n,
  input  core_pkg::reg_idx_t  rs1_addr,
  input  core_pkg::reg_idx_t  rs2_addr,
  input  core_pkg::wb_write_t wb,
  output core_pkg::xlen_t     rs1_val,
  output core_pkg::xlen_t     rs2_val
);
  import core_pkg::*;

  xlen_t regs [1:31];

  // x0 reads zero, a same-cycle write shows through
  function automatic xlen_t read_port(input reg_idx_t idx, input wb_write_t w,
                                      input xlen_t stored);
    if (idx == '0) begin
      return '0;
    end else if (w.en && w.idx == idx) begin
      return w.data;
    end
    return stored;
  endfunction

  assign rs1_val = read_port(rs1_addr, wb, (rs1_addr == '0) ? '0 : regs[rs1_addr]);
  assign rs2_val = read_port(rs2_addr, wb, (rs2_addr == '0) ? '0 : regs[rs2_addr]);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.en && wb.idx != '0) begin
      regs[wb.idx] <= wb.data;
    end
  end

endmodule

`default_nettype wire

/* logic/inst_execute.sv */
`timescale 1ns/1ps
`default_nettype none

module inst_execute (
  input  logic                clk,
  input  logic                rst_n,
  input  core_pkg::id_ex_t    id_ex,
  input  core_pkg::wb_write_t wb,
  output core_pkg::ex_mem_t   ex_mem
);
  import core_pkg::*;

  xlen_t op_a;
  xlen_t op_b;
  xlen_t rs2_fwd;
  xlen_t alu_res;
  logic  ex_fwd_ok;

  // a load in ex_mem only has its address, not the data
  assign ex_fwd_ok = ex_mem.valid & ex_mem.wr_reg & ~ex_mem.load & (ex_mem.rd != '0);

  // youngest producer first
  function automatic xlen_t pick_operand(
    input reg_idx_t  idx,
    input xlen_t     dec_val,
    input logic      ex_ok,
    input ex_mem_t   em,
    input wb_write_t w
  );
    if (ex_ok && em.rd == idx) begin
      return em.result;
    end else if (w.en && w.idx == idx) begin
      return w.data;
    end
    return dec_val;
  endfunction

  assign op_a    = pick_operand(id_ex.rs1, id_ex.rs1_val, ex_fwd_ok, ex_mem, wb);
  assign rs2_fwd = pick_operand(id_ex.rs2, id_ex.rs2_val, ex_fwd_ok, ex_mem, wb);
  assign op_b    = id_ex.use_imm ? id_ex.imm : rs2_fwd;

  // loads and stores come through as ALU_ADD, giving rs1 + imm
  always_comb begin
    case (id_ex.alu_op)
      ALU_ADD:    alu_res = op_a + op_b;
      ALU_SUB:    alu_res = op_a - op_b;
      ALU_AND:    alu_res = op_a & op_b;
      ALU_OR:     alu_res = op_a | op_b;
      ALU_XOR:    alu_res = op_a ^ op_b;
      ALU_PASS_B: alu_res = op_b;
      default:    alu_res = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ex_mem.valid  <= 1'b0;
      ex_mem.wr_reg <= 1'b0;
      ex_mem.load   <= 1'b0;
      ex_mem.store  <= 1'b0;
    end else begin
      ex_mem.valid      <= id_ex.valid;
      ex_mem.wr_reg     <= id_ex.valid & id_ex.wr_reg;
      ex_mem.load       <= id_ex.valid & id_ex.load;
      ex_mem.store      <= id_ex.valid & id_ex.store;
      ex_mem.rd         <= id_ex.rd;
      ex_mem.result     <= alu_res;
      ex_mem.size       <= id_ex.size;
      ex_mem.store_data <= rs2_fwd;
    end
  end

endmodule

`default_nettype wire

/* logic/inst_memacc.sv */
`timescale 1ns/1ps
`default_nettype none

module inst_memacc (
  input  logic                clk,
  input  logic                rst_n,
  input  core_pkg::ex_mem_t   ex_mem,
  input  core_pkg::xlen_t     dsram_rdata,
  output core_pkg::xlen_t     dsram_addr,
  output logic                dsram_cs,
  output logic                dsram_we,
  output core_pkg::byte_en_t  dsram_ben,
  output core_pkg::xlen_t     dsram_wdata,
  output core_pkg::wb_write_t wb
);
  import core_pkg::*;

  logic     wb_en_q;
  reg_idx_t wb_rd_q;
  logic     wb_load_q;
  xlen_t    wb_result_q;

  assign dsram_cs   = ex_mem.valid & (ex_mem.load | ex_mem.store);
  assign dsram_we   = ex_mem.valid & ex_mem.store;
  assign dsram_addr = {ex_mem.result[XLEN-1:2], 2'b00};

  // lanes from size and low address bits, data copied to every lane
  always_comb begin
    case (ex_mem.size)
      SIZE_BYTE: begin
        dsram_ben   = byte_en_t'(4'b0001 << ex_mem.result[1:0]);
        dsram_wdata = {4{ex_mem.store_data[7:0]}};
      end
      SIZE_HALF: begin
        dsram_ben   = ex_mem.result[1] ? 4'b1100 : 4'b0011;
        dsram_wdata = {2{ex_mem.store_data[15:0]}};
      end
      default: begin
        dsram_ben   = 4'b1111;
        dsram_wdata = ex_mem.store_data;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wb_en_q <= 1'b0;
    end else begin
      wb_en_q     <= ex_mem.valid & ex_mem.wr_reg & (ex_mem.rd != '0);
      wb_rd_q     <= ex_mem.rd;
      wb_load_q   <= ex_mem.load;
      wb_result_q <= ex_mem.result;
    end
  end

  // load data arrives from the sram in this cycle
  always_comb begin
    wb.en   = wb_en_q;
    wb.idx  = wb_rd_q;
    wb.data = wb_load_q ? dsram_rdata : wb_result_q;
  end

endmodule

`default_nettype wire

/* logic/core.sv */
`timescale 1ns/1ps
`default_nettype none

module core (
  input  logic               clk,
  input  logic               rst_n,
  input  core_pkg::xlen_t    boot_addr,
  input  core_pkg::xlen_t    instr_fromsram,
  input  core_pkg::xlen_t    dsram_rdata,
  output logic               isram_cs,
  output core_pkg::iaddr_t   isram_adr,
  output core_pkg::xlen_t    dsram_addr,
  output logic               dsram_cs,
  output logic               dsram_we,
  output core_pkg::byte_en_t dsram_ben,
  output core_pkg::xlen_t    dsram_wdata
);
  import core_pkg::*;

  logic      fetch_valid;
  logic      load_stall;
  reg_idx_t  rs1_addr;
  reg_idx_t  rs2_addr;
  xlen_t     rs1_val;
  xlen_t     rs2_val;
  id_ex_t    id_ex;
  ex_mem_t   ex_mem;
  wb_write_t wb;

  fetch fetch_u (
    .clk         (clk),
    .rst_n       (rst_n),
    .boot_addr   (boot_addr),
    .load_stall  (load_stall),
    .isram_cs    (isram_cs),
    .isram_adr   (isram_adr),
    .fetch_valid (fetch_valid)
  );

  inst_decode inst_decode_u (
    .clk            (clk),
    .rst_n          (rst_n),
    .fetch_valid    (fetch_valid),
    .instr_fromsram (instr_fromsram),
    .rs1_val        (rs1_val),
    .rs2_val        (rs2_val),
    .rs1_addr       (rs1_addr),
    .rs2_addr       (rs2_addr),
    .load_stall     (load_stall),
    .id_ex          (id_ex)
  );

  regfile regfile_u (
    .clk      (clk),
    .rst_n    (rst_n),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .wb       (wb),
    .rs1_val  (rs1_val),
    .rs2_val  (rs2_val)
  );

  inst_execute inst_execute_u (
    .clk    (clk),
    .rst_n  (rst_n),
    .id_ex  (id_ex),
    .wb     (wb),
    .ex_mem (ex_mem)
  );

  inst_memacc inst_memacc_u (
    .clk         (clk),
    .rst_n       (rst_n),
    .ex_mem      (ex_mem),
    .dsram_rdata (dsram_rdata),
    .dsram_addr  (dsram_addr),
    .dsram_cs    (dsram_cs),
    .dsram_we    (dsram_we),
    .dsram_ben   (dsram_ben),
    .dsram_wdata (dsram_wdata),
    .wb          (wb)
  );

endmodule

`default_nettype wire

/* sim/core_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module core_properties (
  input logic             clk,
  input logic             rst_n,
  input core_pkg::xlen_t  boot_addr,
  input logic             isram_cs,
  input core_pkg::iaddr_t isram_adr,
  input logic             dsram_cs,
  input logic             dsram_we
);
  import core_pkg::*;

  logic        in_reset_q;
  logic        live;
  int unsigned fail_count = 0;

  // live follows the fetch unit's run flag
  always_ff @(posedge clk) begin
    in_reset_q <= ~rst_n;
    if (!rst_n) begin
      live <= 1'b0;
    end else begin
      live <= 1'b1;
    end
  end

  a_quiet_in_reset: assert property (@(posedge clk)
    in_reset_q |-> !isram_cs && !dsram_cs && !dsram_we)
    else begin
      fail_count++;
      $error("memory strobe while the core is held in reset");
    end

  a_first_fetch: assert property (@(posedge clk)
    $rose(live) |-> isram_cs && isram_adr == boot_addr[XLEN-1:2])
    else begin
      fail_count++;
      $error("first fetch is not at the boot address");
    end

  a_next_word: assert property (@(posedge clk) disable iff (!rst_n)
    isram_cs |=> isram_adr == $past(isram_adr) + iaddr_t'(1))
    else begin
      fail_count++;
      $error("fetch address did not advance by one word");
    end

  // a load-use stall lasts one cycle, right before the load strobe
  a_stall_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
    live && !isram_cs |=> isram_cs)
    else begin
      fail_count++;
      $error("fetch stalled for more than one cycle");
    end

  a_stall_before_load: assert property (@(posedge clk) disable iff (!rst_n)
    live && !isram_cs |=> dsram_cs && !dsram_we)
    else begin
      fail_count++;
      $error("fetch stall not followed by a load strobe");
    end

  a_we_needs_cs: assert property (@(posedge clk)
    dsram_we |-> dsram_cs)
    else begin
      fail_count++;
      $error("data write enable without chip select");
    end

endmodule

bind core core_properties core_properties_u (
  .clk       (clk),
  .rst_n     (rst_n),
  .boot_addr (boot_addr),
  .isram_cs  (isram_cs),
  .isram_adr (isram_adr),
  .dsram_cs  (dsram_cs),
  .dsram_we  (dsram_we)
);

`default_nettype wire

/* sim/core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module core_tb;
  import core_pkg::*;

  localparam int    ROM_WORDS  = 512;
  localparam int    DMEM_WORDS = 64;
  localparam int    N_RANDOM   = 200;
  localparam int    TIMEOUT    = 2000;
  localparam xlen_t BOOT       = 32'h0000_0400;

  typedef struct packed {
    xlen_t    addr;
    byte_en_t ben;
    xlen_t    data;
  } store_rec_t;

  logic     clk;
  logic     rst_n;
  xlen_t    boot_addr;
  xlen_t    instr_fromsram;
  xlen_t    dsram_rdata;
  logic     isram_cs;
  iaddr_t   isram_adr;
  xlen_t    dsram_addr;
  logic     dsram_cs;
  logic     dsram_we;
  byte_en_t dsram_ben;
  xlen_t    dsram_wdata;

  xlen_t      rom [ROM_WORDS];
  xlen_t      dmem [DMEM_WORDS];
  xlen_t      ref_regs [32];
  xlen_t      ref_mem [DMEM_WORDS];
  store_rec_t exp_q [$];
  integer     seed;
  int         prog_len;
  int         ref_stalls;
  int         stall_cycles;
  int         store_count;
  int         store_errors;
  int         stall_errors;
  int         timeout_errors;
  int         prop_errors;
  int         cyc;
  logic       fetch_seen;
  iaddr_t     fetch_end;

  core u_core (
    .clk            (clk),
    .rst_n          (rst_n),
    .boot_addr      (boot_addr),
    .instr_fromsram (instr_fromsram),
    .dsram_rdata    (dsram_rdata),
    .isram_cs       (isram_cs),
    .isram_adr      (isram_adr),
    .dsram_addr     (dsram_addr),
    .dsram_cs       (dsram_cs),
    .dsram_we       (dsram_we),
    .dsram_ben      (dsram_ben),
    .dsram_wdata    (dsram_wdata)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic xlen_t r_type(input logic [6:0] f7, input reg_idx_t rs2,
                                   input reg_idx_t rs1, input logic [2:0] f3,
                                   input reg_idx_t rd);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
  endfunction

  function automatic xlen_t i_type(input logic [11:0] imm, input reg_idx_t rs1,
                                   input logic [2:0] f3, input reg_idx_t rd,
                                   input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic xlen_t s_type(input logic [11:0] imm, input reg_idx_t rs2,
                                   input reg_idx_t rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
  endfunction

  function automatic xlen_t u_type(input logic [19:0] imm, input reg_idx_t rd);
    return {imm, rd, OPC_LUI};
  endfunction

  // every byte lane carries the word index
  function automatic xlen_t fill_word(input int idx);
    return (xlen_t'(idx) * 32'h0101_0101) ^ 32'hc3a5_5a3c;
  endfunction

  function automatic xlen_t rom_word(input iaddr_t wa);
    iaddr_t idx;
    idx = wa - BOOT[XLEN-1:2];
    if (idx < ROM_WORDS) begin
      return rom[idx[8:0]];
    end
    return NOP_INSTR;
  endfunction

  function automatic logic reads_reg(input xlen_t instr, input reg_idx_t r);
    case (instr[6:0])
      OPC_OP, OPC_STORE: return instr[19:15] == r || instr[24:20] == r;
      OPC_OP_IMM, OPC_LOAD: return instr[19:15] == r;
      default: return 1'b0;
    endcase
  endfunction

  task automatic add_instr(input xlen_t instr);
    rom[prog_len] = instr;
    prog_len++;
  endtask

  // x0..x7 only, memory ops based on x0 so addresses stay in 64 words
  task automatic add_random_instr();
    int         kind;
    reg_idx_t   rd;
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    logic [7:0] off;
    kind = $unsigned($random(seed)) % 10;
    rd   = reg_idx_t'($unsigned($random(seed)) % 8);
    rs1  = reg_idx_t'($unsigned($random(seed)) % 8);
    rs2  = reg_idx_t'($unsigned($random(seed)) % 8);
    off  = 8'($unsigned($random(seed)));
    case (kind)
      0: add_instr(r_type(7'h00, rs2, rs1, 3'b000, rd));
      1: add_instr(r_type(7'h20, rs2, rs1, 3'b000, rd));
      2: add_instr(r_type(7'h00, rs2, rs1, 3'b100, rd));
      3: add_instr(r_type(7'h00, rs2, rs1, 3'b110, rd));
      4: add_instr(r_type(7'h00, rs2, rs1, 3'b111, rd));
      5: add_instr(i_type(12'($random(seed)), rs1, 3'b000, rd, OPC_OP_IMM));
      6: add_instr(u_type(20'($random(seed)), rd));
      7: add_instr(i_type({4'h0, off & 8'hfc}, 5'd0, 3'b010, rd, OPC_LOAD));
      8: add_instr(s_type({4'h0, off}, rs2, 5'd0, 3'b000));
      default: begin
        if (off[0]) begin
          add_instr(s_type({4'h0, off & 8'hfe}, rs2, 5'd0, 3'b001));
        end else begin
          add_instr(s_type({4'h0, off & 8'hfc}, rs2, 5'd0, 3'b010));
        end
      end
    endcase
  endtask

  task automatic build_program();
    add_instr(u_type(20'h12345, 5'd1));
    add_instr(s_type(12'h000, 5'd1, 5'd0, 3'b010));
    add_instr(i_type(12'h678, 5'd1, 3'b000, 5'd1, OPC_OP_IMM));
    add_instr(i_type(12'hfff, 5'd0, 3'b000, 5'd2, OPC_OP_IMM));
    add_instr(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));
    add_instr(r_type(7'h20, 5'd3, 5'd1, 3'b000, 5'd4));
    add_instr(r_type(7'h00, 5'd4, 5'd3, 3'b111, 5'd5));
    add_instr(r_type(7'h00, 5'd5, 5'd4, 3'b110, 5'd6));
    add_instr(r_type(7'h00, 5'd6, 5'd5, 3'b100, 5'd7));
    // a write to x0 must not leak through the bypass
    add_instr(r_type(7'h00, 5'd7, 5'd0, 3'b000, 5'd0));
    add_instr(s_type(12'h008, 5'd0, 5'd0, 3'b010));
    add_instr(s_type(12'h004, 5'd7, 5'd0, 3'b010));
    add_instr(i_type(12'h040, 5'd0, 3'b000, 5'd5, OPC_OP_IMM));
    add_instr(s_type(12'h004, 5'd6, 5'd5, 3'b010));
    add_instr(i_type(12'h004, 5'd0, 3'b010, 5'd2, OPC_LOAD));
    add_instr(r_type(7'h00, 5'd2, 5'd2, 3'b000, 5'd3));
    add_instr(s_type(12'h00c, 5'd3, 5'd0, 3'b010));
    for (int off = 0; off < 4; off++) begin
      add_instr(s_type(12'h010 + 12'(off), 5'd1, 5'd0, 3'b000));
    end
    add_instr(s_type(12'h014, 5'd1, 5'd0, 3'b001));
    add_instr(s_type(12'h016, 5'd1, 5'd0, 3'b001));
    for (int i = 0; i < N_RANDOM; i++) begin
      add_random_instr();
    end
  endtask

  // in-order ISA model, stores go to the expected queue
  task automatic run_model();
    xlen_t      instr;
    xlen_t      a;
    xlen_t      b;
    xlen_t      res;
    xlen_t      addr;
    reg_idx_t   rd;
    store_rec_t rec;
    for (int i = 0; i < prog_len; i++) begin
      instr = rom[i];
      rd    = instr[11:7];
      a     = ref_regs[instr[19:15]];
      b     = ref_regs[instr[24:20]];
      res   = '0;
      case (instr[6:0])
        OPC_OP: begin
          case (instr[14:12])
            3'b000: res = instr[30] ? a - b : a + b;
            3'b100: res = a ^ b;
            3'b110: res = a | b;
            default: res = a & b;
          endcase
        end
        OPC_OP_IMM: res = a + {{20{instr[31]}}, instr[31:20]};
        OPC_LUI: res = {instr[31:12], 12'h000};
        OPC_LOAD: begin
          addr = a + {{20{instr[31]}}, instr[31:20]};
          res  = ref_mem[addr[7:2]];
        end
        OPC_STORE: begin
          addr     = a + {{20{instr[31]}}, instr[31:25], instr[11:7]};
          rec.addr = {addr[31:2], 2'b00};
          case (instr[13:12])
            2'b00: begin
              rec.ben  = 4'b0001 << addr[1:0];
              rec.data = {4{b[7:0]}};
            end
            2'b01: begin
              rec.ben  = addr[1] ? 4'b1100 : 4'b0011;
              rec.data = {2{b[15:0]}};
            end
            default: begin
              rec.ben  = 4'b1111;
              rec.data = b;
            end
          endcase
          for (int l = 0; l < 4; l++) begin
            if (rec.ben[l]) begin
              ref_mem[addr[7:2]][8*l +: 8] = rec.data[8*l +: 8];
            end
          end
          exp_q.push_back(rec);
        end
        default: res = '0;
      endcase
      if (instr[6:0] != OPC_STORE && rd != '0) begin
        ref_regs[rd] = res;
      end
      if (instr[6:0] == OPC_LOAD && rd != '0 && reads_reg(rom[i + 1], rd)) begin
        ref_stalls++;
      end
    end
  endtask

  always @(posedge clk) begin
    if (isram_cs) begin
      instr_fromsram <= rom_word(isram_adr);
    end
  end

  // read data only changes on a read strobe
  always @(posedge clk) begin
    if (dsram_cs) begin
      if (dsram_we) begin
        for (int l = 0; l < 4; l++) begin
          if (dsram_ben[l]) begin
            dmem[dsram_addr[7:2]][8*l +: 8] <= dsram_wdata[8*l +: 8];
          end
        end
      end else begin
        dsram_rdata <= dmem[dsram_addr[7:2]];
      end
    end
  end

  always @(negedge clk) begin
    if (rst_n && fetch_seen && !isram_cs) begin
      stall_cycles++;
    end
    if (rst_n && isram_cs) begin
      fetch_seen = 1'b1;
    end
  end

  always @(negedge clk) begin
    store_rec_t want;
    if (rst_n && dsram_cs && dsram_we) begin
      store_count++;
      assert (exp_q.size() != 0) else begin
        store_errors++;
        $display("store to %h arrived after all expected stores were seen", dsram_addr);
      end
      if (exp_q.size() != 0) begin
        want = exp_q.pop_front();
        assert (dsram_addr == want.addr) else begin
          store_errors++;
          $display("** Error @ %0t: store %0d address %h, expected %h",
                   $time, store_count, dsram_addr, want.addr);
        end
        assert (dsram_ben == want.ben) else begin
          store_errors++;
          $display("** Error @ %0t: store %0d lanes %b, expected %b",
                   $time, store_count, dsram_ben, want.ben);
        end
        assert (dsram_wdata == want.data) else begin
          store_errors++;
          $display("** Error @ %0t: store %0d data %h, expected %h",
                   $time, store_count, dsram_wdata, want.data);
        end
      end
    end
  end

  initial begin
    seed           = 32'h78c347a9;
    rst_n          = 1'b0;
    boot_addr      = BOOT;
    instr_fromsram = NOP_INSTR;
    dsram_rdata    = '0;
    prog_len       = 0;
    ref_stalls     = 0;
    stall_cycles   = 0;
    store_count    = 0;
    store_errors   = 0;
    stall_errors   = 0;
    timeout_errors = 0;
    fetch_seen     = 1'b0;
    for (int i = 0; i < ROM_WORDS; i++) begin
      rom[i] = NOP_INSTR;
    end
    for (int i = 0; i < DMEM_WORDS; i++) begin
      dmem[i]    = fill_word(i);
      ref_mem[i] = fill_word(i);
    end
    for (int i = 0; i < 32; i++) begin
      ref_regs[i] = '0;
    end
    build_program();
    run_model();
    fetch_end = BOOT[XLEN-1:2] + iaddr_t'(prog_len + 4);

    repeat (8) @(posedge clk);
    rst_n <= 1'b1;

    // until every store is seen and fetch has left the program
    cyc = 0;
    while (!(exp_q.size() == 0 && isram_adr > fetch_end) && cyc < TIMEOUT) begin
      @(negedge clk);
      cyc++;
    end
    assert (cyc < TIMEOUT) else begin
      timeout_errors++;
      $display("timeout: %0d expected stores missing or fetch never passed the program end",
               exp_q.size());
    end
    assert (stall_cycles == ref_stalls) else begin
      stall_errors++;
      $display("** Error @ %0t: %0d fetch stall cycles, expected %0d",
               $time, stall_cycles, ref_stalls);
    end

    prop_errors = u_core.core_properties_u.fail_count;
    $display("errors: store %0d, stall %0d, timeout %0d, property %0d",
             store_errors, stall_errors, timeout_errors, prop_errors);
    if (store_errors + stall_errors + timeout_errors + prop_errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* compile.f */
logic/core_pkg.sv
logic/fetch.sv
logic/inst_decode.sv
logic/regfile.sv
logic/inst_execute.sv
logic/inst_memacc.sv
logic/core.sv
sim/core_properties.sv
sim/core_tb.sv

/* Bender.yml */
package:
  name: core

sources:
  - logic/core_pkg.sv
  - logic/fetch.sv
  - logic/inst_decode.sv
  - logic/regfile.sv
  - logic/inst_execute.sv
  - logic/inst_memacc.sv
  - logic/core.sv
  - target: simulation
    files:
      - sim/core_properties.sv
      - sim/core_tb.sv
